//--- all.f
rtl/sp_main_pkg.sv
rtl/bf_ctrl_fsm.sv
rtl/bf_addr_cnt.sv
rtl/bf_stave_sum.sv
rtl/bf_pad_join.sv
rtl/sp_main_top.sv
tb/tb_sp_main_top.sv

//--- Bender.yml
package:
  name: sp_main

sources:
  - rtl/sp_main_pkg.sv
  - rtl/bf_ctrl_fsm.sv
  - rtl/bf_addr_cnt.sv
  - rtl/bf_stave_sum.sv
  - rtl/bf_pad_join.sv
  - rtl/sp_main_top.sv
  - target: simulation
    files:
      - tb/tb_sp_main_top.sv

//--- tb/tb_sp_main_top.sv
// testbench for the sonar beamforming frame sequencer
// clock and reset, LFSR stimulus, input RAM model with random latency,
// reference queues for reads and output words, compare tasks, timeout
`timescale 1ns/1ps

module tb_sp_main_top;

	import sp_main_pkg::*;

	localparam int RESET_CYC   = 16;                    // cycles of reset
	localparam int FRAMES      = 8;                     // frames per run
	localparam int TIMEOUT_CYC = RESET_CYC + FRAMES * 200;

	logic   i_clk156m;
	logic   i_reset;
	logic   i_sp_start;
	frame_t i_frame_time;
	word_t  o_iram_rd_addr;
	logic   o_iram_rd_en;
	word_t  i_iram_rd_data;
	logic   i_iram_rd_valid;
	word_t  o_oram_wr_data;
	logic   o_oram_wr_valid;
	logic   o_calc_start;
	logic   o_sp_end;

	int          cyc = 0;                                // posedge count
	int          mis_errs = 0;                           // wrong values
	int          oth_errs = 0;                           // protocol failures
	logic [31:0] stim_st = 32'hf434_10ad;                // LFSR for gaps, frame time
	logic [31:0] lat_st  = 32'hf434_10ad;                // LFSR for RAM latency
	word_t       exp_addr[$];                            // expected read addresses
	word_t       exp_out[$];                             // expected output words
	logic        exp_last[$];                            // marks the end code slot
	word_t       rq_data[$];                             // RAM returns in flight
	int          rq_due[$];
	int          last_due = 0;
	logic        started = 1'b0;                         // first start given
	int          start_cyc = -10;                        // cycle of accepted start
	int          end_wr_cyc = -10;                       // cycle of end code write
	int          calc_cnt = 0;                           // per frame counts
	int          rd_cnt = 0;
	int          wr_cnt = 0;
	int          sp_end_cnt = 0;

	sp_main_top DUT (.*);

	// --------------------
	// helpers
	function automatic logic [31:0] rand_bits(inout logic [31:0] st, input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			st = {st[30:0], st[31] ^ st[21] ^ st[1] ^ st[0]};  // taps 32 22 2 1
			r  = {r[30:0], st[0]};
		end
		return r;
	endfunction

	// RAM content, every address bit matters
	function automatic word_t ram_word(input word_t a);
		return (a * 32'h9e37_79b9) ^ {a[7:0], a[31:8]} ^ 32'h3c5a_0f96;
	endfunction

	task automatic check_word(input string name, input word_t got, input word_t want);
		if (got !== want) begin
			$display("mismatch %s: got %h expected %h at cycle %0d", name, got, want, cyc);
			mis_errs++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic want);
		if (got !== want) begin
			$display("mismatch %s: got %h expected %h at cycle %0d", name, got, want, cyc);
			mis_errs++;
		end
	endtask

	task automatic check_count(input string name, input int got, input int want);
		if (got != want) begin
			$display("mismatch %s: got %h expected %h at cycle %0d", name, got, want, cyc);
			mis_errs++;
		end
	endtask

	// reference model of one frame
	task automatic queue_frame(input frame_t ft);
		word_t base;
		word_t a;
		word_t sum;
		base = word_t'(ft) * FRAME_OFFSET;
		for (int r = 0; r < CALC_NUM; r++) begin
			for (int s = 0; s < SAMPLE_NUM; s++) begin
				sum = '0;
				for (int st = 0; st < STAVE_NUM; st++) begin
					a = base + word_t'(r * RUN_WORDS + s * STAVE_NUM + st);
					exp_addr.push_back(a);
					sum = sum + ram_word(a);               // 32-bit wrap
				end
				exp_out.push_back(sum);
				exp_last.push_back(1'b0);
			end
		end
		for (int p = 0; p < PAD_SIZE; p++) begin
			exp_out.push_back(PAD_WORD);
			exp_last.push_back(1'b0);
		end
		exp_out.push_back(END_CODE);
		exp_last.push_back(1'b1);
	endtask

	// --------------------
	// clock, cycle count, timeout
	initial begin
		i_clk156m = 1'b0;
		forever #10 i_clk156m = ~i_clk156m;               // 20 ns period
	end

	always @(posedge i_clk156m) begin
		cyc <= cyc + 1;
		if (cyc == TIMEOUT_CYC) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
			$display("errors: %0d mismatches, %0d other failures", mis_errs, oth_errs);
			$display("Simulation FAILED");
			$finish;
		end
	end

	// --------------------
	// RAM model and monitor, all on the falling edge
	always @(negedge i_clk156m) begin : monitor
		word_t e;
		logic  last;
		int    due;
		if (cyc > RESET_CYC) begin
			if (rq_data.size() > 0 && rq_due[0] <= cyc) begin  // in order return
				i_iram_rd_valid <= 1'b1;
				i_iram_rd_data  <= rq_data.pop_front();
				void'(rq_due.pop_front());
			end else begin
				i_iram_rd_valid <= 1'b0;
			end
			if (!started) begin                            // quiet before first start
				check_bit("o_iram_rd_en", o_iram_rd_en, 1'b0);
				check_bit("o_oram_wr_valid", o_oram_wr_valid, 1'b0);
				check_bit("o_calc_start", o_calc_start, 1'b0);
				check_bit("o_sp_end", o_sp_end, 1'b0);
			end
			if (o_iram_rd_en) begin
				rd_cnt++;
				due = cyc + 1 + int'(rand_bits(lat_st, 2)); // 1 to 4 cycles
				if (due <= last_due) due = last_due + 1;
				last_due = due;
				rq_data.push_back(ram_word(o_iram_rd_addr));
				rq_due.push_back(due);
				if (exp_addr.size() == 0) begin
					$display("read at cycle %0d while no read was expected", cyc);
					oth_errs++;
				end else begin
					check_word("o_iram_rd_addr", o_iram_rd_addr, exp_addr.pop_front());
				end
			end
			if (o_oram_wr_valid) begin
				wr_cnt++;
				if (exp_out.size() == 0) begin
					$display("output write at cycle %0d while none was expected", cyc);
					oth_errs++;
				end else begin
					e    = exp_out.pop_front();
					last = exp_last.pop_front();
					check_word("o_oram_wr_data", o_oram_wr_data, e);
					if (last) end_wr_cyc = cyc;
				end
			end
			if (o_calc_start) calc_cnt++;
			if (cyc == start_cyc + 1) check_bit("o_calc_start", o_calc_start, 1'b1);
			if (o_sp_end) begin
				sp_end_cnt++;
				if (cyc != end_wr_cyc + 1) begin
					$display("o_sp_end at cycle %0d does not follow the end code write", cyc);
					oth_errs++;
				end
				check_count("o_calc_start pulses", calc_cnt, CALC_NUM);
				check_count("reads per frame", rd_cnt, CALC_NUM * RUN_WORDS);
				check_count("writes per frame", wr_cnt, CALC_NUM * SAMPLE_NUM + PAD_SIZE + 1);
				calc_cnt = 0;
				rd_cnt   = 0;
				wr_cnt   = 0;
			end
		end
	end

	// --------------------
	// stimulus
	initial begin
		i_reset         = 1'b1;
		i_sp_start      = 1'b0;
		i_frame_time    = '0;
		i_iram_rd_data  = '0;
		i_iram_rd_valid = 1'b0;
		repeat (RESET_CYC) @(negedge i_clk156m);
		i_reset = 1'b0;
		repeat (6) @(negedge i_clk156m);                  // idle window for the quiet check
		for (int f = 0; f < FRAMES; f++) begin
			repeat (1 + int'(rand_bits(stim_st, 3))) @(negedge i_clk156m);
			i_frame_time = frame_t'(rand_bits(stim_st, FRAME_W));
			i_sp_start   = 1'b1;                          // DUT idle, start accepted
			started      = 1'b1;
			start_cyc    = cyc;
			queue_frame(i_frame_time);
			@(negedge i_clk156m);
			i_sp_start = 1'b0;
			repeat (4 + int'(rand_bits(stim_st, 2))) @(negedge i_clk156m);
			i_frame_time = frame_t'(rand_bits(stim_st, FRAME_W));
			i_sp_start   = 1'b1;                          // frame busy, must be ignored
			@(negedge i_clk156m);
			i_sp_start = 1'b0;
			do @(negedge i_clk156m); while (!o_sp_end);
		end
		repeat (20) @(negedge i_clk156m);
		if (exp_addr.size() != 0 || exp_out.size() != 0) begin
			$display("%0d reads and %0d output words never appeared",
				exp_addr.size(), exp_out.size());
			oth_errs++;
		end
		check_count("o_sp_end pulses", sp_end_cnt, FRAMES);
		$display("errors: %0d mismatches, %0d other failures", mis_errs, oth_errs);
		if (mis_errs + oth_errs == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

//--- rtl/sp_main_top.sv
// sonar beamforming frame sequencer top level
// frame FSM, read address counter, stave sum and pad/join stage
`timescale 1ns/1ps

module sp_main_top (
	input  logic                i_clk156m,             // system clock
	input  logic                i_reset,               // sync reset, active high
	input  logic                i_sp_start,            // frame start pulse
	input  sp_main_pkg::frame_t i_frame_time,          // frame count
	output sp_main_pkg::word_t  o_iram_rd_addr,        // input RAM read address
	output logic                o_iram_rd_en,          // input RAM read strobe
	input  sp_main_pkg::word_t  i_iram_rd_data,        // input RAM read data
	input  logic                i_iram_rd_valid,       // input RAM read data valid
	output sp_main_pkg::word_t  o_oram_wr_data,        // output RAM write data
	output logic                o_oram_wr_valid,       // output RAM write strobe
	output logic                o_calc_start,          // run start pulse
	output logic                o_sp_end               // frame completion pulse
);

	import sp_main_pkg::*;

	// --------------------
	// internal nets
	logic  w_calc_start;                               // fsm => addr_cnt, out
	word_t w_base_addr;                                // fsm => addr_cnt
	logic  w_run_last;                                 // addr_cnt => fsm
	logic  w_calc_end;                                 // stave_sum => fsm
	word_t w_bm_data;                                  // stave_sum => pad_join
	logic  w_bm_valid;                                 // stave_sum => pad_join
	logic  w_join_start;                               // fsm => pad_join
	logic  w_join_end;                                 // pad_join => fsm

	assign o_calc_start = w_calc_start;

	// --------------------
	// sub modules
	bf_ctrl_fsm u_ctrl_fsm (
		.i_clk156m    ( i_clk156m    ),
		.i_reset      ( i_reset      ),
		.i_sp_start   ( i_sp_start   ),
		.i_frame_time ( i_frame_time ),
		.i_run_last   ( w_run_last   ),
		.i_calc_end   ( w_calc_end   ),
		.i_join_end   ( w_join_end   ),
		.o_calc_start ( w_calc_start ),
		.o_base_addr  ( w_base_addr  ),
		.o_join_start ( w_join_start ),
		.o_sp_end     ( o_sp_end     )
	);

	bf_addr_cnt u_addr_cnt (
		.i_clk156m      ( i_clk156m      ),
		.i_reset        ( i_reset        ),
		.i_calc_start   ( w_calc_start   ),
		.i_base_addr    ( w_base_addr    ),
		.o_iram_rd_addr ( o_iram_rd_addr ),
		.o_iram_rd_en   ( o_iram_rd_en   ),
		.o_run_last     ( w_run_last     )
	);

	bf_stave_sum u_stave_sum (
		.i_clk156m  ( i_clk156m       ),
		.i_reset    ( i_reset         ),
		.i_rd_data  ( i_iram_rd_data  ),
		.i_rd_valid ( i_iram_rd_valid ),
		.o_bm_data  ( w_bm_data       ),
		.o_bm_valid ( w_bm_valid      ),
		.o_calc_end ( w_calc_end      )
	);

	bf_pad_join u_pad_join (
		.i_clk156m       ( i_clk156m       ),
		.i_reset         ( i_reset         ),
		.i_join_start    ( w_join_start    ),
		.i_bm_data       ( w_bm_data       ),
		.i_bm_valid      ( w_bm_valid      ),
		.o_oram_wr_data  ( o_oram_wr_data  ),
		.o_oram_wr_valid ( o_oram_wr_valid ),
		.o_join_end      ( w_join_end      )
	);

endmodule

//--- rtl/bf_pad_join.sv
// output join stage
// registers beam words to the output RAM, then appends
// the pad words and the end code of a frame
`timescale 1ns/1ps

module bf_pad_join (
	input  logic               i_clk156m,              // system clock
	input  logic               i_reset,                // sync reset, active high
	input  logic               i_join_start,           // padding start pulse
	input  sp_main_pkg::word_t i_bm_data,              // beam word
	input  logic               i_bm_valid,             // beam word valid
	output sp_main_pkg::word_t o_oram_wr_data,         // output RAM write data
	output logic               o_oram_wr_valid,        // output RAM write strobe
	output logic               o_join_end              // end code written
);

	import sp_main_pkg::*;

	logic             pad_act;                         // padding in progress
	logic [PAD_W-1:0] pad_cnt;                         // index of next pad slot
	logic             pad_go;                          // a pad slot is emitted now
	logic             pad_end;                         // this slot is the end code

	assign pad_go  = i_join_start || pad_act;
	assign pad_end = (pad_cnt == PAD_W'(PAD_SIZE));

	// --------------------
	// pad sequencing
	always_ff @(posedge i_clk156m) begin
		if (i_reset) begin
			pad_act         <= 1'b0;
			pad_cnt         <= '0;
			o_oram_wr_valid <= 1'b0;
			o_join_end      <= 1'b0;
		end else begin
			o_oram_wr_valid <= i_bm_valid || pad_go;
			o_join_end      <= pad_go && pad_end;       // with the end code write
			if (pad_go) begin
				if (pad_end) begin
					pad_act <= 1'b0;
					pad_cnt <= '0;
				end else begin
					pad_act <= 1'b1;
					pad_cnt <= pad_cnt + 1'b1;
				end
			end
		end
	end

	// write data mux, pads win
	always_ff @(posedge i_clk156m) begin
		if (pad_go) begin
			o_oram_wr_data <= pad_end ? END_CODE : PAD_WORD;
		end else if (i_bm_valid) begin
			o_oram_wr_data <= i_bm_data;
		end
	end

	// --------------------
	// beam words of the last run have all drained before padding starts
	a_no_beam_in_pad: assert property (@(posedge i_clk156m) disable iff (i_reset)
		pad_go |-> !i_bm_valid)
		else $error("beam word arrived during padding");

endmodule

//--- rtl/bf_stave_sum.sv
// stave summation
// accumulates returned read words over the staves of a sample,
// emits one beam word per sample and flags the last one of a run
`timescale 1ns/1ps

module bf_stave_sum (
	input  logic               i_clk156m,              // system clock
	input  logic               i_reset,                // sync reset, active high
	input  sp_main_pkg::word_t i_rd_data,              // RAM read data
	input  logic               i_rd_valid,             // RAM read data valid
	output sp_main_pkg::word_t o_bm_data,              // beam word
	output logic               o_bm_valid,             // beam word valid
	output logic               o_calc_end              // last beam word of run
);

	import sp_main_pkg::*;

	logic [STAVE_W-1:0]  stv_cnt;                      // returned stave index
	logic [SAMPLE_W-1:0] smpl_cnt;                     // returned sample index
	word_t               acc;                          // running stave sum
	word_t               acc_nxt;
	logic                stv_last;
	logic                smpl_last;

	assign stv_last  = (stv_cnt == STAVE_W'(STAVE_NUM - 1));
	assign smpl_last = (smpl_cnt == SAMPLE_W'(SAMPLE_NUM - 1));

	// first stave restarts the sum, 32-bit wrap
	assign acc_nxt = ((stv_cnt == '0) ? '0 : acc) + i_rd_data;

	// --------------------
	// return counters and strobes
	always_ff @(posedge i_clk156m) begin
		if (i_reset) begin
			stv_cnt    <= '0;
			smpl_cnt   <= '0;
			o_bm_valid <= 1'b0;
			o_calc_end <= 1'b0;
		end else begin
			o_bm_valid <= i_rd_valid && stv_last;       // sample complete
			o_calc_end <= i_rd_valid && stv_last && smpl_last;
			if (i_rd_valid) begin
				if (stv_last) begin
					stv_cnt  <= '0;
					smpl_cnt <= smpl_last ? '0 : smpl_cnt + 1'b1;
				end else begin
					stv_cnt <= stv_cnt + 1'b1;
				end
			end
		end
	end

	// --------------------
	// data path
	always_ff @(posedge i_clk156m) begin
		if (i_rd_valid) begin
			acc <= acc_nxt;
			if (stv_last) o_bm_data <= acc_nxt;         // beam word out next cycle
		end
	end

endmodule

//--- rtl/bf_addr_cnt.sv
// input RAM read address generator
// stave, sample and run counters, one read per cycle during a run
`timescale 1ns/1ps

module bf_addr_cnt (
	input  logic               i_clk156m,              // system clock
	input  logic               i_reset,                // sync reset, active high
	input  logic               i_calc_start,           // run start pulse
	input  sp_main_pkg::word_t i_base_addr,            // frame base address
	output sp_main_pkg::word_t o_iram_rd_addr,         // read address
	output logic               o_iram_rd_en,           // read strobe
	output logic               o_run_last              // current run is last of frame
);

	import sp_main_pkg::*;

	logic [STAVE_W-1:0]  stv_cnt;                      // stave within sample
	logic [SAMPLE_W-1:0] smpl_cnt;                     // sample within run
	logic [CALC_W-1:0]   run_cnt;                      // run within frame
	word_t               base_q;                       // latched frame base
	logic                stv_last;
	logic                smpl_last;

	assign stv_last   = (stv_cnt == STAVE_W'(STAVE_NUM - 1));
	assign smpl_last  = (smpl_cnt == SAMPLE_W'(SAMPLE_NUM - 1));
	assign o_run_last = (run_cnt == CALC_W'(CALC_NUM - 1));

	// --------------------
	// read counters
	always_ff @(posedge i_clk156m) begin
		if (i_reset) begin
			o_iram_rd_en <= 1'b0;
			stv_cnt      <= '0;
			smpl_cnt     <= '0;
			run_cnt      <= '0;
		end else if (i_calc_start) begin
			o_iram_rd_en <= 1'b1;                       // reads start next cycle
			stv_cnt      <= '0;
			smpl_cnt     <= '0;
		end else if (o_iram_rd_en) begin
			if (stv_last) begin
				stv_cnt <= '0;
				if (smpl_last) begin
					smpl_cnt     <= '0;
					o_iram_rd_en <= 1'b0;                // run fully issued
					run_cnt      <= o_run_last ? '0 : run_cnt + 1'b1; // wrap per frame
				end else begin
					smpl_cnt <= smpl_cnt + 1'b1;
				end
			end else begin
				stv_cnt <= stv_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk156m) begin
		if (i_calc_start) base_q <= i_base_addr;
	end

	// base + run*RUN_WORDS + sample*STAVE_NUM + stave
	assign o_iram_rd_addr = base_q
		+ word_t'(run_cnt) * word_t'(RUN_WORDS)
		+ word_t'(smpl_cnt) * word_t'(STAVE_NUM)
		+ word_t'(stv_cnt);

	// --------------------
	// the FSM may only kick a run once the previous one is issued
	a_no_overlap: assert property (@(posedge i_clk156m) disable iff (i_reset)
		i_calc_start |-> !o_iram_rd_en)
		else $error("calc start while reads still issuing");

endmodule

//--- rtl/bf_ctrl_fsm.sv
// frame control FSM
// accepts the start pulse, kicks each calc run, then padding,
// then raises the frame completion pulse
`timescale 1ns/1ps

module bf_ctrl_fsm (
	input  logic                i_clk156m,             // system clock
	input  logic                i_reset,               // sync reset, active high
	input  logic                i_sp_start,            // frame start pulse
	input  sp_main_pkg::frame_t i_frame_time,          // frame count, taken at start
	input  logic                i_run_last,            // starting run is last of frame
	input  logic                i_calc_end,            // last beam word of run emitted
	input  logic                i_join_end,            // end code written
	output logic                o_calc_start,          // run start pulse
	output sp_main_pkg::word_t  o_base_addr,           // frame base read address
	output logic                o_join_start,          // padding start pulse
	output logic                o_sp_end               // frame completion pulse
);

	import sp_main_pkg::*;

	bf_state_e state;                                  // current frame state
	bf_state_e state_nxt;
	logic      run_last_q;                             // current run closes the frame

	// --------------------
	// next state
	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE:  if (i_sp_start) state_nxt = ST_CALC;  // start only taken here
			ST_CALC:  state_nxt = ST_DRAIN;                 // single kick cycle
			ST_DRAIN: begin
				if (i_calc_end) begin
					state_nxt = run_last_q ? ST_PAD : ST_CALC; // next run or padding
				end
			end
			ST_PAD:   if (i_join_end) state_nxt = ST_DONE;
			ST_DONE:  state_nxt = ST_IDLE;
			default:  state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge i_clk156m) begin
		if (i_reset) begin
			state        <= ST_IDLE;
			run_last_q   <= 1'b0;
			o_join_start <= 1'b0;
		end else begin
			state        <= state_nxt;
			if (state == ST_CALC) run_last_q <= i_run_last;   // addr counter still on this run
			o_join_start <= (state == ST_DRAIN) && i_calc_end && run_last_q;
		end
	end

	// base address held for the whole frame
	always_ff @(posedge i_clk156m) begin
		if (state == ST_IDLE && i_sp_start) begin
			o_base_addr <= word_t'(i_frame_time) * FRAME_OFFSET;
		end
	end

	assign o_calc_start = (state == ST_CALC);          // one cycle after start or calc end
	assign o_sp_end     = (state == ST_DONE);          // one cycle after join end

	// --------------------
	// every run end kicks exactly one of the next run and the padding
	a_run_kick: assert property (@(posedge i_clk156m) disable iff (i_reset)
		i_calc_end |=> (o_calc_start != o_join_start))
		else $error("run end not followed by exactly one kick");

endmodule

//--- rtl/sp_main_pkg.sv
// sonar beamforming frame sequencer, shared definitions
// frame geometry counts, counter widths, pad and end code words
// word and frame count types, frame FSM state encoding
package sp_main_pkg;

	// --------------------
	// frame geometry
	localparam int SAMPLE_NUM = 8;                         // samples per calc run
	localparam int STAVE_NUM  = 4;                         // staves summed per sample
	localparam int CALC_NUM   = 2;                         // calc runs per frame
	localparam int PAD_SIZE   = 3;                         // pad words per frame
	localparam int RUN_WORDS  = SAMPLE_NUM * STAVE_NUM;    // input words per run

	// --------------------
	// widths
	localparam int DATA_W   = 32;                          // data word and address
	localparam int FRAME_W  = 4;                           // frame count
	localparam int STAVE_W  = $clog2(STAVE_NUM);           // stave counter
	localparam int SAMPLE_W = $clog2(SAMPLE_NUM);          // sample counter
	localparam int CALC_W   = $clog2(CALC_NUM);            // run counter
	localparam int PAD_W    = $clog2(PAD_SIZE + 1);        // pad counter incl. end code slot

	// --------------------
	// types
	typedef logic [DATA_W-1:0]  word_t;                    // data and addresses
	typedef logic [FRAME_W-1:0] frame_t;                   // frame count

	typedef enum logic [2:0] {
		ST_IDLE,                                           // wait for start pulse
		ST_CALC,                                           // one cycle, kicks a run
		ST_DRAIN,                                          // wait for last beam word of run
		ST_PAD,                                            // padding and end code running
		ST_DONE                                            // one cycle, frame complete
	} bf_state_e;

	// --------------------
	// output stream words
	localparam word_t PAD_WORD     = 32'h0000_0000;        // padding data
	localparam word_t END_CODE     = 32'hFFFF_FFFF;        // end of frame marker
	localparam word_t FRAME_OFFSET = 32'h0000_0100;        // input address step per frame count

endpackage
